// ==== common/ex_pkg.sv ====
package ex_pkg;

    // ****************************************
    // widths
    // ****************************************
    localparam int XLEN    = 64;
    localparam int ILEN    = 32;
    localparam int NUM_GPR = 32;
    localparam int STRB_W  = XLEN / 8;

    typedef logic [XLEN-1:0]            xlen_t;
    typedef logic [ILEN-1:0]            inst_t;
    typedef logic [$clog2(NUM_GPR)-1:0] reg_id_t;
    typedef logic [STRB_W-1:0]          strb_t;

    // sequential fetch step
    localparam xlen_t PC_STEP = 4;

    // ****************************************
    // RV64I major opcodes
    // ****************************************
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // operation class, cls_none retires as a no-op
    typedef enum logic [3:0] {
        cls_none,
        cls_lui,
        cls_auipc,
        cls_jal,
        cls_jalr,
        cls_branch,
        cls_load,
        cls_store,
        cls_alu_reg,
        cls_alu_imm
    } op_class_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_mode_e;

    // decoded control for one instruction
    typedef struct packed {
        op_class_e  op_class;
        alu_mode_e  alu_mode;
        logic [2:0] funct3;
        reg_id_t    rd;
        reg_id_t    rs1;
        reg_id_t    rs2;
        xlen_t      imm;
    } ex_ctrl_t;

    // store request to data memory
    typedef struct packed {
        logic  en;
        xlen_t addr;
        xlen_t data;
        strb_t strb;
    } mem_wr_t;

endpackage

// ==== lsu/load_align.sv ====
`timescale 1ns/1ps

module load_align import ex_pkg::*; (
    input  logic [2:0] funct3,
    input  logic [2:0] addr_low,
    input  xlen_t      rdata,
    output xlen_t      value
);

    xlen_t shifted;

    // addressed byte moved down to lane 0
    assign shifted = rdata >> {addr_low, 3'b000};

    always_comb begin
        case (funct3)
            // lb
            3'b000: begin
                value = {{56{shifted[7]}}, shifted[7:0]};
            end
            // lh
            3'b001: begin
                value = {{48{shifted[15]}}, shifted[15:0]};
            end
            // lw
            3'b010: begin
                value = {{32{shifted[31]}}, shifted[31:0]};
            end
            // ld, whole word as is
            3'b011: begin
                value = rdata;
            end
            // lbu
            3'b100: begin
                value = {56'b0, shifted[7:0]};
            end
            // lhu
            3'b101: begin
                value = {48'b0, shifted[15:0]};
            end
            // lwu
            3'b110: begin
                value = {32'b0, shifted[31:0]};
            end
            default: begin
                value = '0;
            end
        endcase
    end

endmodule

// ==== lsu/store_align.sv ====
`timescale 1ns/1ps

module store_align import ex_pkg::*; (
    input  logic [2:0] funct3,
    input  xlen_t      addr,
    input  xlen_t      src2,
    input  logic       enable,
    output mem_wr_t    wr
);

    xlen_t size_mask;
    strb_t size_strb;
    strb_t strb_norm;

    // sb, sh, sw, sd by funct3[1:0]
    always_comb begin
        case (funct3[1:0])
            2'b00: begin
                size_mask = 64'h0000_0000_0000_00ff;
                size_strb = 8'h01;
            end
            2'b01: begin
                size_mask = 64'h0000_0000_0000_ffff;
                size_strb = 8'h03;
            end
            2'b10: begin
                size_mask = 64'h0000_0000_ffff_ffff;
                size_strb = 8'h0f;
            end
            default: begin
                size_mask = '1;
                size_strb = 8'hff;
            end
        endcase
    end

    // place the value at its byte lane
    assign wr.en   = enable;
    assign wr.addr = addr;
    assign wr.data = (src2 & size_mask) << {addr[2:0], 3'b000};
    assign wr.strb = enable ? (size_strb << addr[2:0]) : '0;

    // strobe folded back to lane 0, must be a run of ones
    assign strb_norm = wr.strb >> addr[2:0];

    always_comb begin
        if (enable) begin
            a_strb_shape: assert (!funct3[2] && strb_norm != '0 &&
                                  (strb_norm & (strb_norm + 1'b1)) == '0)
                else $error("store strobe %b is not a valid lane run", wr.strb);
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the ex_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_ex_stage -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" sim.log; then
    exit 0
fi
exit 1

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu import ex_pkg::*; (
    input  alu_mode_e mode,
    input  xlen_t     a,
    input  xlen_t     b,
    output xlen_t     result
);

    logic [$clog2(XLEN)-1:0] shamt;
    logic                    lt_signed;
    logic                    lt_unsigned;

    // 64-bit shifts only look at b[5:0]
    assign shamt = b[$clog2(XLEN)-1:0];

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (mode)
            alu_add: begin
                result = a + b;
            end
            alu_sub: begin
                result = a - b;
            end
            alu_sll: begin
                result = a << shamt;
            end
            alu_slt: begin
                result = {{(XLEN-1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                result = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_srl: begin
                result = a >> shamt;
            end
            alu_sra: begin
                // arithmetic shift keeps the sign bit
                result = $signed(a) >>> shamt;
            end
            alu_or: begin
                result = a | b;
            end
            alu_and: begin
                result = a & b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== src/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit import ex_pkg::*; (
    input  op_class_e  op_class,
    input  logic [2:0] funct3,
    input  xlen_t      src1,
    input  xlen_t      src2,
    input  xlen_t      pc,
    input  xlen_t      imm,
    input  xlen_t      alu_result,
    output xlen_t      next_pc
);

    xlen_t pc_seq;
    xlen_t pc_target;
    logic  taken;

    assign pc_seq    = pc + PC_STEP;
    assign pc_target = pc + imm;

    // condition per branch funct3
    always_comb begin
        case (funct3)
            3'b000:  taken = (src1 == src2);
            3'b001:  taken = (src1 != src2);
            3'b100:  taken = ($signed(src1) <  $signed(src2));
            3'b101:  taken = ($signed(src1) >= $signed(src2));
            3'b110:  taken = (src1 <  src2);
            3'b111:  taken = (src1 >= src2);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (op_class)
            cls_jal:    next_pc = pc_target;
            // jalr target is rs1 + imm from the alu, lsb dropped
            cls_jalr:   next_pc = {alu_result[XLEN-1:1], 1'b0};
            cls_branch: next_pc = taken ? pc_target : pc_seq;
            default:    next_pc = pc_seq;
        endcase
    end

endmodule

// ==== src/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  xlen_t   in_pc,
    input  inst_t   in_inst,
    input  xlen_t   mem_rdata,
    output logic    out_valid,
    output xlen_t   out_pc,
    output inst_t   out_inst,
    output logic    rd_wen,
    output reg_id_t rd_id,
    output xlen_t   rd_value,
    output xlen_t   next_pc,
    output logic    mem_ren,
    output xlen_t   mem_raddr,
    output mem_wr_t mem_wr
);

    logic     valid_q;
    xlen_t    pc_q;
    inst_t    inst_q;
    inst_t    ex_inst;
    ex_ctrl_t ctrl;
    xlen_t    src1;
    xlen_t    src2;
    xlen_t    op_a;
    xlen_t    op_b;
    xlen_t    alu_result;
    xlen_t    pc_link;
    xlen_t    load_value;

    // ****************************************
    // execute register
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            pc_q   <= in_pc;
            inst_q <= in_inst;
        end
    end

    // empty slot decodes as opcode 0, a no-op
    assign ex_inst = valid_q ? inst_q : '0;

    inst_decoder decoder_i (
        .inst (ex_inst),
        .ctrl (ctrl)
    );

    gpr_file gpr_i (
        .clk       (clk),
        .rst       (rst),
        .rs1       (ctrl.rs1),
        .rs2       (ctrl.rs2),
        .rs1_value (src1),
        .rs2_value (src2),
        .wen       (rd_wen),
        .wd_id     (rd_id),
        .wd_value  (rd_value)
    );

    // pc-relative forms add to the pc, register forms compare rs2
    assign op_a = (ctrl.op_class == cls_auipc || ctrl.op_class == cls_jal) ? pc_q : src1;
    assign op_b = (ctrl.op_class == cls_alu_reg || ctrl.op_class == cls_branch) ? src2 : ctrl.imm;

    alu alu_i (
        .mode   (ctrl.alu_mode),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result)
    );

    branch_unit branch_i (
        .op_class   (ctrl.op_class),
        .funct3     (ctrl.funct3),
        .src1       (src1),
        .src2       (src2),
        .pc         (pc_q),
        .imm        (ctrl.imm),
        .alu_result (alu_result),
        .next_pc    (next_pc)
    );

    store_align store_i (
        .funct3 (ctrl.funct3),
        .addr   (alu_result),
        .src2   (src2),
        .enable (ctrl.op_class == cls_store),
        .wr     (mem_wr)
    );

    load_align load_i (
        .funct3   (ctrl.funct3),
        .addr_low (alu_result[2:0]),
        .rdata    (mem_rdata),
        .value    (load_value)
    );

    // ****************************************
    // write-back select
    // ****************************************
    assign pc_link = pc_q + PC_STEP;

    always_comb begin
        rd_wen   = 1'b0;
        rd_value = alu_result;
        case (ctrl.op_class)
            cls_lui: begin
                rd_wen   = 1'b1;
                rd_value = ctrl.imm;
            end
            cls_auipc, cls_alu_reg, cls_alu_imm: begin
                rd_wen = 1'b1;
            end
            cls_jal, cls_jalr: begin
                rd_wen   = 1'b1;
                rd_value = pc_link;
            end
            cls_load: begin
                rd_wen   = 1'b1;
                rd_value = load_value;
            end
            default: ;
        endcase
    end

    assign rd_id     = ctrl.rd;
    assign mem_ren   = (ctrl.op_class == cls_load);
    assign mem_raddr = alu_result;

    assign out_valid = valid_q;
    assign out_pc    = pc_q;
    assign out_inst  = inst_q;

    // a store never writes back
    a_store_no_wb: assert property (
        @(posedge clk) disable iff (rst)
        !(mem_wr.en && rd_wen)
    ) else $error("store and register write in the same cycle");

endmodule

// ==== src/gpr_file.sv ====
`timescale 1ns/1ps

module gpr_file import ex_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  reg_id_t rs1,
    input  reg_id_t rs2,
    output xlen_t   rs1_value,
    output xlen_t   rs2_value,
    input  logic    wen,
    input  reg_id_t wd_id,
    input  xlen_t   wd_value
);

    xlen_t regs [NUM_GPR];

    // x0 never takes a write
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_GPR; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wd_id != '0) begin
            regs[wd_id] <= wd_value;
        end
    end

    // combinational read, sees a write one cycle after it lands
    assign rs1_value = regs[rs1];
    assign rs2_value = regs[rs2];

    a_x0_zero: assert property (
        @(posedge clk) disable iff (rst)
        regs[0] == '0
    ) else $error("x0 holds a nonzero value");

endmodule

// ==== src/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder import ex_pkg::*; (
    input  inst_t    inst,
    output ex_ctrl_t ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;
    alu_mode_e  fn_mode;
    logic       shift_ok;
    logic       op_ok;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // ****************************************
    // immediates, all sign extended from bit 31
    // ****************************************
    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // funct3 to alu mode, bit 30 picks sra over srl
    always_comb begin
        case (funct3)
            3'b000:  fn_mode = alu_add;
            3'b001:  fn_mode = alu_sll;
            3'b010:  fn_mode = alu_slt;
            3'b011:  fn_mode = alu_sltu;
            3'b100:  fn_mode = alu_xor;
            3'b101:  fn_mode = inst[30] ? alu_sra : alu_srl;
            3'b110:  fn_mode = alu_or;
            default: fn_mode = alu_and;
        endcase
    end

    // 64-bit shift immediates keep shamt[5] in bit 25
    assign shift_ok = (inst[31:26] == 6'b000000) ||
                      (funct3 == 3'b101 && inst[31:26] == 6'b010000);

    // only sub and sra may set funct7 bit 5
    assign op_ok = (funct7 == 7'b0000000) ||
                   (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

    always_comb begin
        ctrl          = '0;
        ctrl.op_class = cls_none;
        ctrl.alu_mode = alu_add;
        ctrl.funct3   = funct3;
        ctrl.rd       = inst[11:7];
        ctrl.rs1      = inst[19:15];
        ctrl.rs2      = inst[24:20];
        case (opcode)
            OPC_LUI: begin
                ctrl.op_class = cls_lui;
                ctrl.imm      = imm_u;
            end
            OPC_AUIPC: begin
                ctrl.op_class = cls_auipc;
                ctrl.imm      = imm_u;
            end
            OPC_JAL: begin
                ctrl.op_class = cls_jal;
                ctrl.imm      = imm_j;
            end
            OPC_JALR: begin
                ctrl.op_class = (funct3 == 3'b000) ? cls_jalr : cls_none;
                ctrl.imm      = imm_i;
            end
            OPC_BRANCH: begin
                ctrl.op_class = (funct3[2:1] == 2'b01) ? cls_none : cls_branch;
                ctrl.imm      = imm_b;
            end
            OPC_LOAD: begin
                ctrl.op_class = (funct3 == 3'b111) ? cls_none : cls_load;
                ctrl.imm      = imm_i;
            end
            OPC_STORE: begin
                ctrl.op_class = funct3[2] ? cls_none : cls_store;
                ctrl.imm      = imm_s;
            end
            OPC_OP_IMM: begin
                if (funct3[1:0] != 2'b01 || shift_ok) begin
                    ctrl.op_class = cls_alu_imm;
                end
                ctrl.alu_mode = fn_mode;
                ctrl.imm      = imm_i;
            end
            OPC_OP: begin
                if (op_ok) begin
                    ctrl.op_class = cls_alu_reg;
                end
                ctrl.alu_mode = (funct3 == 3'b000 && funct7[5]) ? alu_sub : fn_mode;
            end
            default: ;
        endcase
    end

endmodule

// ==== verification/ex_ref_model.svh ====
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// sign extended immediate for each instruction format
function automatic xlen_t imm_of(input inst_t i);
    case (i[6:0])
        OPC_LUI, OPC_AUIPC: imm_of = {{32{i[31]}}, i[31:12], 12'b0};
        OPC_JAL:    imm_of = {{44{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
        OPC_BRANCH: imm_of = {{52{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        OPC_STORE:  imm_of = {{52{i[31]}}, i[31:25], i[11:7]};
        default:    imm_of = {{52{i[31]}}, i[31:20]};
    endcase
endfunction

// alt selects sub or sra
function automatic xlen_t alu_op(input logic [2:0] f3, input logic alt,
                                 input xlen_t a, input xlen_t b);
    case (f3)
        3'd0: alu_op = alt ? a - b : a + b;
        3'd1: alu_op = a << b[5:0];
        3'd2: alu_op = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        3'd3: alu_op = (a < b) ? 64'd1 : 64'd0;
        3'd4: alu_op = a ^ b;
        3'd5: alu_op = alt ? xlen_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
        3'd6: alu_op = a | b;
        default: alu_op = a & b;
    endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input xlen_t a, input xlen_t b);
    case (f3)
        3'd0: branch_taken = (a == b);
        3'd1: branch_taken = (a != b);
        3'd4: branch_taken = ($signed(a) < $signed(b));
        3'd5: branch_taken = ($signed(a) >= $signed(b));
        3'd6: branch_taken = (a < b);
        3'd7: branch_taken = (a >= b);
        default: branch_taken = 1'b0;
    endcase
endfunction

function automatic strb_t lane_strobe(input logic [2:0] f3, input xlen_t addr);
    strb_t base;
    case (f3[1:0])
        2'd0: base = 8'h01;
        2'd1: base = 8'h03;
        2'd2: base = 8'h0f;
        default: base = 8'hff;
    endcase
    lane_strobe = base << addr[2:0];
endfunction

function automatic xlen_t lane_data(input logic [2:0] f3, input xlen_t addr, input xlen_t v);
    xlen_t low;
    case (f3[1:0])
        2'd0: low = {56'b0, v[7:0]};
        2'd1: low = {48'b0, v[15:0]};
        2'd2: low = {32'b0, v[31:0]};
        default: low = v;
    endcase
    lane_data = low << (addr[2:0] * 8);
endfunction

// bytes under the strobe replace the old word
function automatic xlen_t merge_word(input xlen_t old, input strb_t strb, input xlen_t data);
    merge_word = old;
    for (int k = 0; k < 8; k++) begin
        if (strb[k]) begin
            merge_word[8*k +: 8] = data[8*k +: 8];
        end
    end
endfunction

function automatic xlen_t extend_load(input logic [2:0] f3, input xlen_t addr,
                                      input xlen_t word);
    xlen_t s;
    s = word >> (addr[2:0] * 8);
    case (f3)
        3'd0: extend_load = {{56{s[7]}}, s[7:0]};
        3'd1: extend_load = {{48{s[15]}}, s[15:0]};
        3'd2: extend_load = {{32{s[31]}}, s[31:0]};
        3'd3: extend_load = word;
        3'd4: extend_load = {56'b0, s[7:0]};
        3'd5: extend_load = {48'b0, s[15:0]};
        default: extend_load = {32'b0, s[31:0]};
    endcase
endfunction

`endif

// ==== verification/tb_ex_stage.sv ====
`timescale 1ns/1ps

module tb_ex_stage import ex_pkg::*; ();

    localparam int N_RANDOM = 400;
    // setup, random mix, directed pairs, drain slack
    localparam int N_INST   = 4 + N_RANDOM + 44 + 20;
    localparam int LIMIT    = N_INST * 2 + 100;

    logic    clk;
    logic    rst;
    logic    in_valid;
    xlen_t   in_pc;
    inst_t   in_inst;
    xlen_t   mem_rdata;
    logic    out_valid;
    xlen_t   out_pc;
    inst_t   out_inst;
    logic    rd_wen;
    reg_id_t rd_id;
    xlen_t   rd_value;
    xlen_t   next_pc;
    logic    mem_ren;
    xlen_t   mem_raddr;
    mem_wr_t mem_wr;

    integer  seed;
    int      errors;
    int      checks;
    int      test_start;
    xlen_t   fetch_pc;
    xlen_t   shadow [NUM_GPR];
    xlen_t   mem [64];
    logic    exp_valid;
    xlen_t   exp_pc;
    inst_t   exp_inst;
    logic    pend_valid;
    logic [5:0] pend_idx;
    xlen_t   pend_word;

    `include "ex_ref_model.svh"

    ex_stage dut_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_pc     (in_pc),
        .in_inst   (in_inst),
        .mem_rdata (mem_rdata),
        .out_valid (out_valid),
        .out_pc    (out_pc),
        .out_inst  (out_inst),
        .rd_wen    (rd_wen),
        .rd_id     (rd_id),
        .rd_value  (rd_value),
        .next_pc   (next_pc),
        .mem_ren   (mem_ren),
        .mem_raddr (mem_raddr),
        .mem_wr    (mem_wr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ****************************************
    // memory model indexed by addr[8:3]
    // ****************************************
    assign mem_rdata = mem[mem_raddr[8:3]];

    always @(posedge clk) begin
        if (mem_wr.en) begin
            for (int k = 0; k < 8; k++) begin
                if (mem_wr.strb[k]) begin
                    mem[mem_wr.addr[8:3]][8*k +: 8] <= mem_wr.data[8*k +: 8];
                end
            end
        end
    end

    // what the stage should hold after each edge
    always @(posedge clk) begin
        exp_valid <= rst ? 1'b0 : in_valid;
        if (in_valid) begin
            exp_pc   <= in_pc;
            exp_inst <= in_inst;
        end
    end

    function automatic int unsigned rand_below(input int unsigned n);
        rand_below = $unsigned($random(seed)) % n;
    endfunction

    // x1..x4 hold memory bases and are never written by random code
    function automatic reg_id_t pick_rd();
        int unsigned r;
        r = rand_below(25);
        pick_rd = (r == 24) ? 5'd0 : reg_id_t'(r + 8);
    endfunction

    function automatic inst_t make_mem(input logic store, input logic [2:0] f3,
                                       input reg_id_t base, input logic [11:0] off,
                                       input reg_id_t rd, input reg_id_t rs2);
        if (store) begin
            make_mem = {off[11:5], rs2, base, f3, off[4:0], OPC_STORE};
        end else begin
            make_mem = {off, base, f3, rd, OPC_LOAD};
        end
    endfunction

    // naturally aligned offset inside 64 bytes
    function automatic logic [11:0] aligned_off(input logic [1:0] size_log);
        int unsigned size;
        size = 1 << size_log;
        aligned_off = 12'(rand_below(64) & ~(size - 1));
    endfunction

    task automatic make_random_inst(output inst_t inst);
        int unsigned kind;
        int unsigned k;
        logic [2:0]  f3;
        reg_id_t     rd;
        reg_id_t     rs1;
        reg_id_t     rs2;
        logic [11:0] imm12;
        kind  = rand_below(12);
        rd    = pick_rd();
        rs1   = reg_id_t'(rand_below(32));
        rs2   = reg_id_t'(rand_below(32));
        f3    = 3'(rand_below(8));
        imm12 = 12'(rand_below(4096));
        case (kind)
            0, 1: begin
                inst = {((f3 == 3'd0 || f3 == 3'd5) && rand_below(2) == 1) ?
                        7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, OPC_OP};
            end
            2, 3: begin
                if (f3 == 3'd1) begin
                    imm12 = {6'b000000, imm12[5:0]};
                end else if (f3 == 3'd5) begin
                    imm12 = {(rand_below(2) == 1) ? 6'b010000 : 6'b000000, imm12[5:0]};
                end
                inst = {imm12, rs1, f3, rd, OPC_OP_IMM};
            end
            4: inst = {20'($random(seed)), rd, (rand_below(2) == 1) ? OPC_LUI : OPC_AUIPC};
            5: inst = {20'($random(seed)), rd, OPC_JAL};
            6: inst = {imm12, rs1, 3'b000, rd, OPC_JALR};
            7: begin
                k  = rand_below(6);
                f3 = (k < 2) ? 3'(k) : 3'(k + 2);
                inst = {imm12[11:5], rs2, rs1, f3, imm12[4:0], OPC_BRANCH};
            end
            8, 9: begin
                f3 = 3'(rand_below(7));
                inst = make_mem(1'b0, f3, reg_id_t'(1 + rand_below(4)),
                                aligned_off(f3[1:0]), rd, 5'd0);
            end
            10: begin
                f3 = 3'(rand_below(4));
                inst = make_mem(1'b1, f3, reg_id_t'(1 + rand_below(4)),
                                aligned_off(f3[1:0]), 5'd0, rs2);
            end
            // fence is outside the subset
            default: inst = 32'h0000_000f;
        endcase
    endtask

    // about one idle slot in five before each issue
    task automatic issue(input inst_t inst);
        while (rand_below(5) == 0) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
        @(posedge clk);
        in_valid <= 1'b1;
        in_pc    <= fetch_pc;
        in_inst  <= inst;
        fetch_pc = fetch_pc + PC_STEP;
    endtask

    task automatic drain();
        @(posedge clk);
        in_valid <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic check_val(input string name, input xlen_t got, input xlen_t exp);
        checks++;
        a_value: assert (got === exp) else begin
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        $display("test %-10s %s (%0d errors)", name,
                 (errors == test_start) ? "ok" : "failed", errors - test_start);
        test_start = errors;
    endtask

    // ****************************************
    // checker samples outputs mid cycle
    // ****************************************
    task automatic check_cycle();
        logic [6:0] opc;
        logic [2:0] f3;
        reg_id_t    rd;
        xlen_t      a;
        xlen_t      b;
        xlen_t      imm;
        xlen_t      addr;
        xlen_t      val;
        xlen_t      npc;
        logic       wen;
        logic       is_load;
        logic       is_store;
        strb_t      strb;
        xlen_t      data;
        if (pend_valid) begin
            check_val("mem_word", mem[pend_idx], pend_word);
            pend_valid = 1'b0;
        end
        check_val("out_valid", 64'(out_valid), 64'(exp_valid));
        if (!exp_valid) begin
            check_val("rd_wen", 64'(rd_wen), 64'd0);
            check_val("mem_ren", 64'(mem_ren), 64'd0);
            check_val("mem_wr.en", 64'(mem_wr.en), 64'd0);
            return;
        end
        opc      = exp_inst[6:0];
        f3       = exp_inst[14:12];
        rd       = exp_inst[11:7];
        a        = shadow[exp_inst[19:15]];
        b        = shadow[exp_inst[24:20]];
        imm      = imm_of(exp_inst);
        addr     = a + imm;
        npc      = exp_pc + PC_STEP;
        val      = '0;
        wen      = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        case (opc)
            OPC_LUI: begin
                wen = 1'b1;
                val = imm;
            end
            OPC_AUIPC: begin
                wen = 1'b1;
                val = exp_pc + imm;
            end
            OPC_JAL: begin
                wen = 1'b1;
                val = exp_pc + PC_STEP;
                npc = exp_pc + imm;
            end
            OPC_JALR: begin
                wen = 1'b1;
                val = exp_pc + PC_STEP;
                npc = addr & ~64'd1;
            end
            OPC_BRANCH: begin
                if (branch_taken(f3, a, b)) begin
                    npc = exp_pc + imm;
                end
            end
            OPC_LOAD: begin
                wen     = 1'b1;
                is_load = 1'b1;
                val     = extend_load(f3, addr, mem[addr[8:3]]);
            end
            OPC_STORE: is_store = 1'b1;
            OPC_OP_IMM: begin
                wen = 1'b1;
                val = alu_op(f3, f3 == 3'd5 && exp_inst[30], a, imm);
            end
            OPC_OP: begin
                wen = 1'b1;
                val = alu_op(f3, exp_inst[30], a, b);
            end
            default: ;
        endcase
        check_val("out_pc", out_pc, exp_pc);
        check_val("out_inst", 64'(out_inst), 64'(exp_inst));
        check_val("next_pc", next_pc, npc);
        check_val("rd_wen", 64'(rd_wen), 64'(wen));
        check_val("mem_ren", 64'(mem_ren), 64'(is_load));
        check_val("mem_wr.en", 64'(mem_wr.en), 64'(is_store));
        if (wen) begin
            check_val("rd_id", 64'(rd_id), 64'(rd));
            check_val("rd_value", rd_value, val);
            if (rd != 5'd0) begin
                shadow[rd] = val;
            end
        end
        if (is_load) begin
            check_val("mem_raddr", mem_raddr, addr);
        end
        if (is_store) begin
            strb = lane_strobe(f3, addr);
            data = lane_data(f3, addr, b);
            check_val("mem_wr.addr", mem_wr.addr, addr);
            check_val("mem_wr.strb", 64'(mem_wr.strb), 64'(strb));
            check_val("mem_wr.data", mem_wr.data, data);
            pend_valid = 1'b1;
            pend_idx   = addr[8:3];
            pend_word  = merge_word(mem[addr[8:3]], strb, data);
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check_cycle();
        end
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("watchdog expired before all tests finished");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        inst_t       inst;
        reg_id_t     base;
        logic [11:0] off;
        seed       = 87;
        errors     = 0;
        checks     = 0;
        test_start = 0;
        pend_valid = 1'b0;
        fetch_pc   = 64'h1000;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_pc      = '0;
        in_inst    = '0;
        for (int i = 0; i < NUM_GPR; i++) begin
            shadow[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            mem[i] = {32'(i) * 32'h9e37_79b9, ~(32'(i) * 32'h85eb_ca6b)};
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);
        report_test("reset");

        // bases 0, 128, 256, 384 in x1..x4
        for (int r = 1; r <= 4; r++) begin
            issue({12'((r - 1) * 128), 5'd0, 3'b000, reg_id_t'(r), OPC_OP_IMM});
        end
        drain();
        report_test("bases");

        for (int n = 0; n < N_RANDOM; n++) begin
            make_random_inst(inst);
            issue(inst);
        end
        drain();
        report_test("random");

        // store then read back at the same address
        for (int w = 0; w < 4; w++) begin
            repeat (4) begin
                base = reg_id_t'(1 + rand_below(4));
                off  = aligned_off(2'(w));
                issue(make_mem(1'b1, 3'(w), base, off, 5'd0, reg_id_t'(rand_below(32))));
                issue(make_mem(1'b0, 3'(w), base, off, pick_rd(), 5'd0));
                if (w < 3) begin
                    issue(make_mem(1'b0, 3'(w + 4), base, off, pick_rd(), 5'd0));
                end
            end
        end
        drain();
        report_test("store_load");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+verification
common/ex_pkg.sv
src/inst_decoder.sv
src/gpr_file.sv
src/alu.sv
src/branch_unit.sv
lsu/store_align.sv
lsu/load_align.sv
src/ex_stage.sv
verification/tb_ex_stage.sv
